/* fcvt_consts.svh */
`ifndef FCVT_CONSTS_SVH
`define FCVT_CONSTS_SVH

// ROB tag width, shared by both CDBs.
`define ROB_WIDTH 4

// entries in the conversion station.
`define STATION_DEPTH 2

// result buffer slots.
// must cover the two core stages plus one.
`define RESULT_DEPTH 4

`endif

/* fcvt_pkg.sv */
`include "fcvt_consts.svh"

package fcvt_pkg;

	// one CDB beat, also used as a source operand.
	typedef struct packed {
		logic valid;
		logic [`ROB_WIDTH-1:0] tag;
		logic [31:0] data;
	} cdb_t;

	typedef struct packed {
		logic is_unsigned;
		logic rne; // 0 is round toward zero.
	} fcvt_op_t;

	typedef struct packed {
		logic [`ROB_WIDTH-1:0] tag; // destination.
		logic is_unsigned;
		logic rm;
		cdb_t opd;
	} issue_t;

	typedef struct packed {
		logic valid;
		logic [`ROB_WIDTH-1:0] tag;
		fcvt_op_t op;
		cdb_t opd;
	} station_entry_t;

	typedef struct packed {
		logic valid;
		logic [`ROB_WIDTH-1:0] tag;
		fcvt_op_t op;
		logic [31:0] data; // single precision.
	} dispatch_t;

	typedef struct packed {
		logic valid;
		logic [`ROB_WIDTH-1:0] tag;
		logic [31:0] data;
	} result_t;

endpackage

/* fcvt_decode.sv */
`timescale 1ns/1ns

module fcvt_decode import fcvt_pkg::*; (
	input issue_t issue,
	input cdb_t fpr_cdb,
	output station_entry_t entry
);
	logic cdb_hit;
	fcvt_op_t op;

	// producer broadcasting in the issue cycle.
	assign cdb_hit = !issue.opd.valid && fpr_cdb.valid && fpr_cdb.tag == issue.opd.tag;

	always_comb begin
		op.is_unsigned = issue.is_unsigned;
		op.rne = issue.rm;
	end

	always_comb begin
		entry.valid = 1'b1; // qualified by the handshake in the station.
		entry.tag = issue.tag;
		entry.op = op;
		entry.opd.valid = issue.opd.valid || cdb_hit;
		entry.opd.tag = issue.opd.tag;
		entry.opd.data = cdb_hit ? fpr_cdb.data : issue.opd.data;
	end

endmodule

/* fcvt_station.sv */
`timescale 1ns/1ns
`include "fcvt_consts.svh"

module fcvt_station import fcvt_pkg::*; (
	input logic clk,
	input logic reset,
	input station_entry_t entry,
	input logic issue_valid,
	output logic issue_ready,
	input cdb_t fpr_cdb,
	input logic credit_ok,
	output dispatch_t dispatch
);
	localparam int DEPTH = `STATION_DEPTH;
	localparam int SEL_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	station_entry_t e [DEPTH]; // packed from 0, oldest first.
	station_entry_t e_upd [DEPTH];
	station_entry_t e_nxt [DEPTH];
	logic [DEPTH-1:0] ready;
	logic [SEL_W-1:0] sel;
	logic found;
	logic fire;
	logic accept;

	// operand wakeup from the fp CDB.
	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			e_upd[i] = e[i];
			if (e[i].valid && !e[i].opd.valid && fpr_cdb.valid &&
					fpr_cdb.tag == e[i].opd.tag) begin
				e_upd[i].opd.valid = 1'b1;
				e_upd[i].opd.data = fpr_cdb.data;
			end
			ready[i] = e_upd[i].valid && e_upd[i].opd.valid;
		end
	end

	// oldest ready entry wins.
	always_comb begin
		sel = '0;
		found = 1'b0;
		for (int i = DEPTH - 1; i >= 0; i--) begin
			if (ready[i]) begin
				sel = SEL_W'(i);
				found = 1'b1;
			end
		end
	end

	assign fire = found && credit_ok;
	assign issue_ready = !e[DEPTH-1].valid || fire;
	assign accept = issue_valid && issue_ready;

	always_comb begin
		dispatch.valid = fire;
		dispatch.tag = e_upd[sel].tag;
		dispatch.op = e_upd[sel].op;
		dispatch.data = e_upd[sel].opd.data;
	end

	// close the gap left by dispatch, then append at the first free slot.
	always_comb begin
		int src;
		logic placed;
		placed = 1'b0;
		for (int i = 0; i < DEPTH; i++) begin
			src = (fire && i >= int'(sel)) ? i + 1 : i;
			if (src < DEPTH)
				e_nxt[i] = e_upd[src];
			else
				e_nxt[i] = '0;
			if (accept && !placed && !e_nxt[i].valid) begin
				e_nxt[i] = entry;
				placed = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++)
				e[i].valid <= 1'b0;
		end else begin
			e <= e_nxt;
		end
	end

endmodule

/* fcvt_core.sv */
`timescale 1ns/1ns

module fcvt_core import fcvt_pkg::*; (
	input logic clk,
	input logic reset,
	input dispatch_t dispatch,
	output result_t done
);
	typedef struct packed {
		logic [$bits(dispatch.tag)-1:0] tag;
		fcvt_op_t op;
		logic sign;
		logic nan;
		logic big; // magnitude at or above 2^32, or inf.
		logic [31:0] mag;
		logic guard;
		logic sticky;
	} stage_t;

	logic [7:0] exp_in;
	logic [23:0] sig_in;
	logic [7:0] rsh;
	logic [48:0] shifted;
	stage_t s1_in;
	stage_t s1;
	logic s1_valid;

	logic round_up;
	logic [32:0] rounded;
	logic [31:0] res;
	logic done_valid;
	logic [$bits(dispatch.tag)-1:0] done_tag;
	logic [31:0] done_data;

	// stage one. value is sig * 2^(exp - 150).
	always_comb begin
		exp_in = dispatch.data[30:23];
		sig_in = {exp_in != 8'd0, dispatch.data[22:0]};
		rsh = 8'd150 - exp_in;
		shifted = {sig_in, 25'd0} >> ((rsh > 8'd25) ? 8'd25 : rsh); // 25 covers all tiny values.
		s1_in.tag = dispatch.tag;
		s1_in.op = dispatch.op;
		s1_in.sign = dispatch.data[31];
		s1_in.nan = exp_in == 8'hff && dispatch.data[22:0] != 23'd0;
		s1_in.big = exp_in >= 8'd159;
		if (exp_in >= 8'd150) begin
			s1_in.mag = {8'd0, sig_in} << (exp_in - 8'd150);
			s1_in.guard = 1'b0;
			s1_in.sticky = 1'b0;
		end else begin
			s1_in.mag = {8'd0, shifted[48:25]};
			s1_in.guard = shifted[24];
			s1_in.sticky = |shifted[23:0];
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			s1_valid <= 1'b0;
		else
			s1_valid <= dispatch.valid;
	end

	always_ff @(posedge clk)
		s1 <= s1_in;

	// stage two. round, then sign and saturate.
	always_comb begin
		round_up = s1.op.rne && s1.guard && (s1.sticky || s1.mag[0]);
		rounded = {1'b0, s1.mag} + {32'd0, round_up};
		if (s1.nan)
			res = s1.op.is_unsigned ? 32'hffffffff : 32'h7fffffff;
		else if (s1.op.is_unsigned)
			res = s1.sign ? 32'd0 : (s1.big || rounded[32]) ? 32'hffffffff : rounded[31:0];
		else if (!s1.sign)
			res = (s1.big || rounded > 33'h07fffffff) ? 32'h7fffffff : rounded[31:0];
		else
			res = (s1.big || rounded > 33'h080000000) ? 32'h80000000 : ~rounded[31:0] + 32'd1;
	end

	always_ff @(posedge clk) begin
		if (reset)
			done_valid <= 1'b0;
		else
			done_valid <= s1_valid;
	end

	always_ff @(posedge clk) begin
		done_tag <= s1.tag;
		done_data <= res;
	end

	assign done = '{valid: done_valid, tag: done_tag, data: done_data};

endmodule

/* fcvt_result.sv */
`timescale 1ns/1ns
`include "fcvt_consts.svh"

module fcvt_result import fcvt_pkg::*; (
	input logic clk,
	input logic reset,
	input result_t done,
	output logic credit_ok,
	output result_t gpr_cdb,
	input logic gpr_cdb_ready
);
	localparam int DEPTH = `RESULT_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

	result_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic [PTR_W+1:0] committed;
	logic push;
	logic pop;

	assign push = done.valid; // credit keeps this from overflowing.
	assign pop = gpr_cdb.valid && gpr_cdb_ready;

	// first core stage is not visible here, so one slot stays reserved for it.
	assign committed = {1'b0, count} + {{(PTR_W+1){1'b0}}, done.valid} + 1'b1;
	assign credit_ok = committed < (PTR_W+2)'(DEPTH);

	assign gpr_cdb = '{valid: count != '0, tag: mem[rd_ptr].tag, data: mem[rd_ptr].data};

	always_ff @(posedge clk)
		if (push)
			mem[wr_ptr] <= done;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* fcvt_unit.sv */
`timescale 1ns/1ns

module fcvt_unit import fcvt_pkg::*; (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input issue_t issue,
	output logic issue_ready,
	input cdb_t fpr_cdb,
	output result_t gpr_cdb,
	input logic gpr_cdb_ready
);
	station_entry_t entry;
	dispatch_t dispatch;
	result_t done;
	logic credit_ok;

	fcvt_decode u_decode (
		.issue(issue),
		.fpr_cdb(fpr_cdb),
		.entry(entry)
	);

	fcvt_station u_station (
		.clk(clk),
		.reset(reset),
		.entry(entry),
		.issue_valid(issue_valid),
		.issue_ready(issue_ready),
		.fpr_cdb(fpr_cdb),
		.credit_ok(credit_ok),
		.dispatch(dispatch)
	);

	// two cycles from dispatch to done.
	fcvt_core u_execute (
		.clk(clk),
		.reset(reset),
		.dispatch(dispatch),
		.done(done)
	);

	fcvt_result u_result (
		.clk(clk),
		.reset(reset),
		.done(done),
		.credit_ok(credit_ok),
		.gpr_cdb(gpr_cdb),
		.gpr_cdb_ready(gpr_cdb_ready)
	);

endmodule

/* fcvt_assertions.sv */
`timescale 1ns/1ns
`include "fcvt_consts.svh"

module fcvt_assertions import fcvt_pkg::*; (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input issue_t issue,
	input logic issue_ready,
	input result_t gpr_cdb,
	input logic gpr_cdb_ready,
	input dispatch_t dispatch
);
	int fail_count = 0;
	int held; // dispatched and not yet on the integer CDB.

	always_ff @(posedge clk) begin
		if (reset)
			held <= 0;
		else
			held <= held + int'(dispatch.valid) - int'(gpr_cdb.valid && gpr_cdb_ready);
	end

	// issuer holds the request until the station takes it.
	issue_hold: assert property (@(posedge clk) disable iff (reset)
		issue_valid && !issue_ready |=> issue_valid && $stable(issue))
		else begin
			$error("issue payload changed while waiting for issue_ready");
			fail_count++;
		end

	gpr_hold: assert property (@(posedge clk) disable iff (reset)
		gpr_cdb.valid && !gpr_cdb_ready |=> $stable(gpr_cdb)) // stalled beat.
		else begin
			$error("gpr_cdb changed while stalled");
			fail_count++;
		end

	reset_quiet: assert property (@(posedge clk)
		reset |=> !gpr_cdb.valid)
		else begin
			$error("gpr_cdb valid during reset");
			fail_count++;
		end

	// buffer space must be reserved before a conversion starts.
	credit_held: assert property (@(posedge clk) disable iff (reset)
		dispatch.valid |-> held < `RESULT_DEPTH)
		else begin
			$error("dispatch without room in the result buffer");
			fail_count++;
		end

endmodule

bind fcvt_unit fcvt_assertions u_assertions (
	.clk(clk),
	.reset(reset),
	.issue_valid(issue_valid),
	.issue(issue),
	.issue_ready(issue_ready),
	.gpr_cdb(gpr_cdb),
	.gpr_cdb_ready(gpr_cdb_ready),
	.dispatch(dispatch)
);

/* fcvt_tb.sv */
`timescale 1ns/1ns
`include "fcvt_consts.svh"

module fcvt_tb import fcvt_pkg::*; ();
	localparam int TIMEOUT = 200;
	localparam int NTAGS = 1 << `ROB_WIDTH;

	typedef struct packed {
		logic is_issue;
		logic [`ROB_WIDTH-1:0] tag;
		logic is_unsigned;
		logic rm;
		logic [1:0] present; // 2 means a beat in the issue cycle.
		logic [`ROB_WIDTH-1:0] optag;
		logic [31:0] data;
		logic [31:0] expected;
	} vec_t;

	logic clk = 1'b0;
	logic reset;
	logic issue_valid;
	issue_t issue;
	logic issue_ready;
	cdb_t fpr_cdb;
	result_t gpr_cdb;
	logic gpr_cdb_ready;

	logic [31:0] lfsr;
	logic [31:0] expected [NTAGS];
	logic pending [NTAGS];
	vec_t vecs [$];
	int mismatches;
	int failures;
	int issued;
	int retired;

	fcvt_unit u_dut (
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue(issue),
		.issue_ready(issue_ready),
		.fpr_cdb(fpr_cdb),
		.gpr_cdb(gpr_cdb),
		.gpr_cdb_ready(gpr_cdb_ready)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("** Error at %0t ns: %s got %h, expected %h", $time, what, got, want);
			mismatches++;
		end
	endtask

	task automatic load_vectors(output logic ok);
		int fd;
		int cnt;
		string line;
		vec_t v;
		logic [31:0] a, b, c, d, e, g, h;
		ok = 1'b0;
		fd = $fopen("fcvt_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open fcvt_vectors.txt");
			return;
		end
		while (!$feof(fd)) begin
			cnt = $fgets(line, fd);
			if (cnt == 0)
				break;
			v = '0;
			if ($sscanf(line, "I %h %h %h %h %h %h %h", a, b, c, d, e, g, h) == 7) begin
				v.is_issue = 1'b1;
				v.tag = a[`ROB_WIDTH-1:0];
				v.is_unsigned = b[0];
				v.rm = c[0];
				v.present = d[1:0];
				v.optag = e[`ROB_WIDTH-1:0];
				v.data = g;
				v.expected = h;
				vecs.push_back(v);
			end else if ($sscanf(line, "B %h %h", a, b) == 2) begin
				v.optag = a[`ROB_WIDTH-1:0]; // fp producer tag.
				v.data = b;
				vecs.push_back(v);
			end
		end
		$fclose(fd);
		ok = vecs.size() > 0;
		if (!ok)
			$display("no records found in fcvt_vectors.txt");
	endtask

	task automatic send_beat(input vec_t v);
		@(negedge clk);
		issue_valid = 1'b0;
		fpr_cdb = '{valid: 1'b1, tag: v.optag, data: v.data};
		@(posedge clk);
	endtask

	task automatic send_issue(input vec_t v, output logic ok);
		int n;
		logic ready_seen;
		logic accepted;
		ok = 1'b1;
		@(negedge clk);
		issue_valid = 1'b0;
		fpr_cdb = '0;
		n = 0;
		while (pending[v.tag] && n < TIMEOUT) begin // tag still in flight.
			@(negedge clk);
			n++;
		end
		// a same-cycle beat is only seen if the station takes the issue at once.
		ready_seen = v.present != 2'd2;
		while (!ready_seen && n < TIMEOUT) begin
			@(posedge clk);
			ready_seen = issue_ready;
			@(negedge clk);
			n++;
		end
		if (n >= TIMEOUT) begin
			$display("timed out at %0t ns before issuing tag %0d", $time, v.tag);
			failures++;
			ok = 1'b0;
		end else begin
			issue_valid = 1'b1;
			issue.tag = v.tag;
			issue.is_unsigned = v.is_unsigned;
			issue.rm = v.rm;
			issue.opd.valid = v.present == 2'd1;
			issue.opd.tag = v.optag;
			issue.opd.data = (v.present == 2'd1) ? v.data : 32'd0;
			if (v.present == 2'd2)
				fpr_cdb = '{valid: 1'b1, tag: v.optag, data: v.data};
			accepted = 1'b0;
			n = 0;
			while (!accepted && n < TIMEOUT) begin
				@(posedge clk);
				accepted = issue_ready;
				n++;
			end
			if (!accepted) begin
				$display("timed out at %0t ns waiting for issue_ready, tag %0d", $time, v.tag);
				failures++;
				ok = 1'b0;
			end else begin
				expected[v.tag] = v.expected;
				pending[v.tag] = 1'b1;
				issued++;
			end
		end
	endtask

	always @(negedge clk) begin
		lfsr = lfsr_step(lfsr);
		gpr_cdb_ready = lfsr[0];
	end

	// results are matched by tag in whatever order they retire.
	always @(posedge clk) begin
		if (!reset && gpr_cdb.valid === 1'b1 && gpr_cdb_ready) begin
			check($sformatf("tag %0d outstanding", gpr_cdb.tag), 32'(pending[gpr_cdb.tag]), 32'd1);
			check($sformatf("tag %0d result", gpr_cdb.tag), gpr_cdb.data, expected[gpr_cdb.tag]);
			pending[gpr_cdb.tag] = 1'b0;
			retired++;
		end
	end

	initial begin
		logic ok;
		int i;
		int n;
		int asserts;
		reset = 1'b1;
		issue_valid = 1'b0;
		issue = '0;
		fpr_cdb = '0;
		gpr_cdb_ready = 1'b0;
		lfsr = 32'h7ed4;
		mismatches = 0;
		failures = 0;
		issued = 0;
		retired = 0;
		for (i = 0; i < NTAGS; i++) begin
			pending[i] = 1'b0;
			expected[i] = '0;
		end
		load_vectors(ok);
		if (!ok)
			failures++;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check("issue_ready after reset", 32'(issue_ready), 32'd1);
		check("gpr_cdb valid after reset", 32'(gpr_cdb.valid), 32'd0);
		for (i = 0; i < vecs.size() && ok; i++) begin
			if (vecs[i].is_issue)
				send_issue(vecs[i], ok);
			else
				send_beat(vecs[i]);
		end
		@(negedge clk);
		issue_valid = 1'b0;
		fpr_cdb = '0;
		n = 0;
		while (retired < issued && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (retired < issued) begin
			$display("timed out with %0d of %0d results not retired", issued - retired, issued);
			failures++;
		end
		check("retired count", retired, issued);
		asserts = u_dut.u_assertions.fail_count;
		$display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatches, failures, asserts);
		if (mismatches == 0 && failures == 0 && asserts == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+.
fcvt_pkg.sv
fcvt_decode.sv
fcvt_station.sv
fcvt_core.sv
fcvt_result.sv
fcvt_unit.sv
fcvt_assertions.sv
fcvt_tb.sv

/* fcvt_vectors.txt */
# I tag unsigned rm present optag data expected (present 0 waits, 1 ready, 2 beat in issue cycle)
# B fp_tag data
I 0 0 0 1 0 3f800000 00000001
I 1 0 1 1 0 40200000 00000002
I 2 0 1 1 0 40600000 00000004
I 3 0 0 1 0 40600000 00000003
I 4 0 1 1 0 c0600000 fffffffc
I 5 0 0 1 0 c0600000 fffffffd
I 6 1 1 1 0 3f000000 00000000
I 7 1 1 1 0 42cb0000 00000066
I 8 0 1 1 0 ce6e6b28 c4653600
I 9 1 0 1 0 4f7fffff ffffff00
I a 0 0 1 0 7fc00000 7fffffff
I b 1 0 1 0 ffc00000 ffffffff
I c 0 1 1 0 7f800000 7fffffff
I d 1 1 1 0 ff800000 00000000
I e 0 0 1 0 cf800000 80000000
I f 1 1 1 0 bf800000 00000000
I 0 0 1 1 0 4f000000 7fffffff
I 1 1 1 1 0 4f000000 80000000
I 2 0 0 1 0 cf000000 80000000
I 3 0 1 0 9 00000000 00000004
I 4 0 1 1 0 3fc00000 00000002
I 5 0 1 1 0 bf400000 ffffffff
B 9 40600000
I 6 0 0 0 d 00000000 00000064
I 7 1 1 0 e 00000000 00000003
B e 40300000
B d 42c90000
I 8 0 1 2 c 3fc00000 00000002
I 9 1 1 2 5 4f800000 ffffffff
I a 0 1 1 0 42c90000 00000064
I b 0 1 1 0 4e6e6b28 3b9aca00
I c 0 0 1 0 bf400000 00000000
I d 1 1 1 0 40200000 00000002
